//--- fc_hwpe_config.svh
//--------------------------------------
// bus and length widths of the subsystem
// the TCDM and APB address widths are shared
// the length limits a job to 4095 words
//--------------------------------------
`ifndef FC_HWPE_CONFIG_SVH
`define FC_HWPE_CONFIG_SVH

// address width of both TCDM ports and of APB
`define HWPE_ADDR_WIDTH 32

// word width of TCDM data, APB data and the result
`define HWPE_DATA_WIDTH 32

// width of the vector length in words
`define HWPE_LEN_WIDTH 12

`endif

//--- hwpe_pkg.sv
//--------------------------------------
// bus, job and state types of the HWPE
// widths come from fc_hwpe_config.svh
//--------------------------------------
`default_nettype none

`include "fc_hwpe_config.svh"

package hwpe_pkg;

    // TCDM request, wen high means a read
    typedef struct packed {
        logic                            req;
        logic [`HWPE_ADDR_WIDTH-1:0]     add;
        logic                            wen;
        logic [`HWPE_DATA_WIDTH/8-1:0]   be;
        logic [`HWPE_DATA_WIDTH-1:0]     wdata;
    } tcdm_req_t;

    typedef struct packed {
        logic                            gnt;
        logic [`HWPE_DATA_WIDTH-1:0]     r_rdata;
        logic                            r_valid;
    } tcdm_rsp_t;

    typedef struct packed {
        logic                            psel;
        logic                            penable;
        logic                            pwrite;
        logic [`HWPE_ADDR_WIDTH-1:0]     paddr;
        logic [`HWPE_DATA_WIDTH-1:0]     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`HWPE_DATA_WIDTH-1:0]     prdata;
        logic                            pready;
        logic                            pslverr;
    } apb_rsp_t;

    // start is high for one cycle, the other fields are levels
    typedef struct packed {
        logic [`HWPE_ADDR_WIDTH-1:0]     src_a;
        logic [`HWPE_ADDR_WIDTH-1:0]     src_b;
        logic [`HWPE_LEN_WIDTH-1:0]      len;
        logic                            start;
    } hwpe_job_t;

    typedef enum logic [7:0] {
        REG_SRC_A  = 8'h00,
        REG_SRC_B  = 8'h04,
        REG_LEN    = 8'h08,
        REG_CTRL   = 8'h0C,
        REG_STATUS = 8'h10,
        REG_RESULT = 8'h14
    } hwpe_reg_e;

    typedef enum logic [1:0] {
        L_IDLE,
        L_REQ,
        L_WAIT,
        L_HOLD
    } loader_state_e;

    typedef enum logic [1:0] {
        M_IDLE,
        M_RUN,
        M_DONE
    } mac_state_e;

endpackage

`default_nettype wire

//--- hwpe_cfg_regs.sv
//--------------------------------------
// APB register file of the HWPE
// only paddr[7:0] is decoded, no wait states
// STATUS and RESULT ignore writes
// a CTRL write while busy is refused
//--------------------------------------
`default_nettype none

`include "fc_hwpe_config.svh"

module hwpe_cfg_regs (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  hwpe_pkg::apb_req_t          apb_req_i,
    output hwpe_pkg::apb_rsp_t          apb_rsp_o,
    input  logic                        busy_i,
    input  logic [`HWPE_DATA_WIDTH-1:0] result_i,
    output hwpe_pkg::hwpe_job_t         job_o
);
    import hwpe_pkg::*;

    logic [`HWPE_ADDR_WIDTH-1:0] src_a_q;
    logic [`HWPE_ADDR_WIDTH-1:0] src_b_q;
    logic [`HWPE_LEN_WIDTH-1:0]  len_q;
    logic                        start_q;
    logic                        access;
    logic                        mapped;
    logic                        busy;
    logic                        ctrl_blocked;
    logic                        wr_en;
    hwpe_reg_e                   offset;
    logic [`HWPE_DATA_WIDTH-1:0] rdata;

    // the access phase of APB, pready is tied high
    assign access = apb_req_i.psel & apb_req_i.penable;
    assign offset = hwpe_reg_e'(apb_req_i.paddr[7:0]);

    // start_q covers the cycle before the engine raises its busy
    assign busy = busy_i | start_q;

    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (offset)
            REG_SRC_A:  rdata = src_a_q;
            REG_SRC_B:  rdata = src_b_q;
            REG_LEN:    rdata[`HWPE_LEN_WIDTH-1:0] = len_q;
            REG_CTRL:   rdata = '0;
            REG_STATUS: rdata[0] = busy;
            REG_RESULT: rdata = result_i;
            default:    mapped = 1'b0;
        endcase
    end

    assign ctrl_blocked = (offset == REG_CTRL) & apb_req_i.pwrite & busy;
    assign wr_en        = access & apb_req_i.pwrite & mapped & ~ctrl_blocked;

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = access & (~mapped | ctrl_blocked);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_a_q <= '0;
            src_b_q <= '0;
            len_q   <= '0;
            start_q <= 1'b0;
        end else begin
            // the start pulse follows the committed CTRL write by one cycle
            start_q <= wr_en & (offset == REG_CTRL);
            if (wr_en) begin
                case (offset)
                    REG_SRC_A: src_a_q <= apb_req_i.pwdata;
                    REG_SRC_B: src_b_q <= apb_req_i.pwdata;
                    REG_LEN:   len_q   <= apb_req_i.pwdata[`HWPE_LEN_WIDTH-1:0];
                    default:   ;
                endcase
            end
        end
    end

    assign job_o.src_a = src_a_q;
    assign job_o.src_b = src_b_q;
    assign job_o.len   = len_q;
    assign job_o.start = start_q;

endmodule

`default_nettype wire

//--- hwpe_stream_loader.sv
//--------------------------------------
// reads one vector over a TCDM port
// one request in flight, be is all ones
// a start is only taken while idle
//--------------------------------------
`default_nettype none

`include "fc_hwpe_config.svh"

module hwpe_stream_loader (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  hwpe_pkg::hwpe_job_t         job_i,
    input  logic                        sel_b_i,
    output hwpe_pkg::tcdm_req_t         tcdm_req_o,
    input  hwpe_pkg::tcdm_rsp_t         tcdm_rsp_i,
    output logic [`HWPE_DATA_WIDTH-1:0] data_o,
    output logic                        valid_o,
    input  logic                        pop_i
);
    import hwpe_pkg::*;

    loader_state_e               state_q;
    loader_state_e               state_d;
    logic [`HWPE_ADDR_WIDTH-1:0] addr_q;
    logic [`HWPE_LEN_WIDTH-1:0]  left_q;
    logic [`HWPE_DATA_WIDTH-1:0] data_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            L_IDLE: begin
                if (job_i.start && job_i.len != '0) begin
                    state_d = L_REQ;
                end
            end
            // add stays on the bus until the memory grants it
            L_REQ: begin
                if (tcdm_rsp_i.gnt) begin
                    state_d = L_WAIT;
                end
            end
            L_WAIT: begin
                if (tcdm_rsp_i.r_valid) begin
                    state_d = L_HOLD;
                end
            end
            L_HOLD: begin
                if (pop_i) begin
                    state_d = (left_q == `HWPE_LEN_WIDTH'(1)) ? L_IDLE : L_REQ;
                end
            end
            default: state_d = L_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= L_IDLE;
            addr_q  <= '0;
            left_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == L_IDLE && job_i.start) begin
                addr_q <= sel_b_i ? job_i.src_b : job_i.src_a;
                left_q <= job_i.len;
            end else if (state_q == L_HOLD && pop_i) begin
                addr_q <= addr_q + `HWPE_ADDR_WIDTH'(4);
                left_q <= left_q - `HWPE_LEN_WIDTH'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == L_WAIT && tcdm_rsp_i.r_valid) begin
            data_q <= tcdm_rsp_i.r_rdata;
        end
    end

    assign tcdm_req_o.req   = (state_q == L_REQ);
    assign tcdm_req_o.add   = addr_q;
    assign tcdm_req_o.wen   = 1'b1;
    assign tcdm_req_o.be    = '1;
    assign tcdm_req_o.wdata = '0;

    assign data_o  = data_q;
    assign valid_o = (state_q == L_HOLD);

endmodule

`default_nettype wire

//--- hwpe_mac_engine.sv
//--------------------------------------
// dot product of two word streams
// products and sum wrap modulo 2^32
// a start is only taken while idle
//--------------------------------------
`default_nettype none

`include "fc_hwpe_config.svh"

module hwpe_mac_engine (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  hwpe_pkg::hwpe_job_t         job_i,
    input  logic [`HWPE_DATA_WIDTH-1:0] a_i,
    input  logic                        a_valid_i,
    input  logic [`HWPE_DATA_WIDTH-1:0] b_i,
    input  logic                        b_valid_i,
    output logic                        pop_o,
    output logic [`HWPE_DATA_WIDTH-1:0] result_o,
    output logic                        busy_o,
    output logic                        evt_o
);
    import hwpe_pkg::*;

    mac_state_e                  state_q;
    mac_state_e                  state_d;
    logic [`HWPE_LEN_WIDTH-1:0]  cnt_q;
    logic [`HWPE_DATA_WIDTH-1:0] acc_q;
    logic [`HWPE_DATA_WIDTH-1:0] prod;
    logic                        fire;

    // a pair is consumed only when both loaders hold a word
    assign fire = (state_q == M_RUN) && (cnt_q != '0) && a_valid_i && b_valid_i;

    // the result width keeps only the low half of the product
    assign prod = a_i * b_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            M_IDLE: begin
                if (job_i.start) begin
                    state_d = M_RUN;
                end
            end
            M_RUN: begin
                if (cnt_q == '0) begin
                    state_d = M_DONE;
                end
            end
            M_DONE:  state_d = M_IDLE;
            default: state_d = M_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= M_IDLE;
            cnt_q   <= '0;
            acc_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == M_IDLE && job_i.start) begin
                cnt_q <= job_i.len;
                acc_q <= '0;
            end else if (fire) begin
                cnt_q <= cnt_q - `HWPE_LEN_WIDTH'(1);
                acc_q <= acc_q + prod;
            end
        end
    end

    assign pop_o    = fire;
    assign result_o = acc_q;
    // busy falls in the same cycle as the single event pulse
    assign busy_o   = (state_q == M_RUN);
    assign evt_o    = (state_q == M_DONE);

endmodule

`default_nettype wire

//--- fc_hwpe.sv
//--------------------------------------
// dot product HWPE, APB config and two
// read-only TCDM master ports
// loader A uses src_a, loader B uses src_b
//--------------------------------------
`default_nettype none

`include "fc_hwpe_config.svh"

module fc_hwpe (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  hwpe_pkg::apb_req_t  apb_req_i,
    output hwpe_pkg::apb_rsp_t  apb_rsp_o,
    output hwpe_pkg::tcdm_req_t tcdm_a_req_o,
    input  hwpe_pkg::tcdm_rsp_t tcdm_a_rsp_i,
    output hwpe_pkg::tcdm_req_t tcdm_b_req_o,
    input  hwpe_pkg::tcdm_rsp_t tcdm_b_rsp_i,
    output logic                evt_o,
    output logic                busy_o
);
    import hwpe_pkg::*;

    hwpe_job_t                   job;
    logic [`HWPE_DATA_WIDTH-1:0] a_data;
    logic                        a_valid;
    logic [`HWPE_DATA_WIDTH-1:0] b_data;
    logic                        b_valid;
    logic                        pop;
    logic [`HWPE_DATA_WIDTH-1:0] result;

    hwpe_cfg_regs i_cfg_regs (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .apb_req_i ( apb_req_i ),
        .apb_rsp_o ( apb_rsp_o ),
        .busy_i    ( busy_o    ),
        .result_i  ( result    ),
        .job_o     ( job       )
    );

    hwpe_stream_loader i_loader_a (
        .clk_i      ( clk_i        ),
        .rst_n_i    ( rst_n_i      ),
        .job_i      ( job          ),
        .sel_b_i    ( 1'b0         ),
        .tcdm_req_o ( tcdm_a_req_o ),
        .tcdm_rsp_i ( tcdm_a_rsp_i ),
        .data_o     ( a_data       ),
        .valid_o    ( a_valid      ),
        .pop_i      ( pop          )
    );

    hwpe_stream_loader i_loader_b (
        .clk_i      ( clk_i        ),
        .rst_n_i    ( rst_n_i      ),
        .job_i      ( job          ),
        .sel_b_i    ( 1'b1         ),
        .tcdm_req_o ( tcdm_b_req_o ),
        .tcdm_rsp_i ( tcdm_b_rsp_i ),
        .data_o     ( b_data       ),
        .valid_o    ( b_valid      ),
        .pop_i      ( pop          )
    );

    hwpe_mac_engine i_mac_engine (
        .clk_i     ( clk_i   ),
        .rst_n_i   ( rst_n_i ),
        .job_i     ( job     ),
        .a_i       ( a_data  ),
        .a_valid_i ( a_valid ),
        .b_i       ( b_data  ),
        .b_valid_i ( b_valid ),
        .pop_o     ( pop     ),
        .result_o  ( result  ),
        .busy_o    ( busy_o  ),
        .evt_o     ( evt_o   )
    );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
//--------------------------------------
// free running testbench clock
// 20 ns period, starts low at time 0
//--------------------------------------
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 10;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- tb_fc_hwpe_sva.sv
//--------------------------------------
// protocol checker bound to fc_hwpe
// fail_count is read by the testbench
// all properties are off during reset
//--------------------------------------
`default_nettype none

module tb_fc_hwpe_sva (
    input logic                clk_i,
    input logic                rst_n_i,
    input hwpe_pkg::tcdm_req_t tcdm_a_req_i,
    input hwpe_pkg::tcdm_rsp_t tcdm_a_rsp_i,
    input hwpe_pkg::tcdm_req_t tcdm_b_req_i,
    input hwpe_pkg::tcdm_rsp_t tcdm_b_rsp_i,
    input logic                evt_i,
    input logic                busy_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // a request may not move or vanish before the memory grants it
    a_req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tcdm_a_req_i.req && !tcdm_a_rsp_i.gnt |=>
            tcdm_a_req_i.req && $stable(tcdm_a_req_i.add))
        else begin
            $error("port A request changed before gnt");
            fail_count++;
        end

    a_req_stable_b: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tcdm_b_req_i.req && !tcdm_b_rsp_i.gnt |=>
            tcdm_b_req_i.req && $stable(tcdm_b_req_i.add))
        else begin
            $error("port B request changed before gnt");
            fail_count++;
        end

    a_evt_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        evt_i |=> !evt_i)
        else begin
            $error("evt_o stayed high for more than one cycle");
            fail_count++;
        end

    // the loaders only run inside a job, so no request outside busy
    a_idle_no_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !busy_i |-> !tcdm_a_req_i.req && !tcdm_b_req_i.req)
        else begin
            $error("TCDM request while the subsystem is idle");
            fail_count++;
        end

endmodule

bind fc_hwpe tb_fc_hwpe_sva i_sva (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .tcdm_a_req_i ( tcdm_a_req_o ),
    .tcdm_a_rsp_i ( tcdm_a_rsp_i ),
    .tcdm_b_req_i ( tcdm_b_req_o ),
    .tcdm_b_rsp_i ( tcdm_b_rsp_i ),
    .evt_i        ( evt_o        ),
    .busy_i       ( busy_o       )
);

`default_nettype wire

//--- tb_fc_hwpe.sv
//--------------------------------------
// testbench of the dot product HWPE
// both memories hold 16 words, indexed by add[5:2]
// inputs change on the falling clock edge
//--------------------------------------
`default_nettype none

`include "fc_hwpe_config.svh"

module tb_fc_hwpe;
    timeunit 1ns;
    timeprecision 100ps;

    import hwpe_pkg::*;

    localparam int          CLK_PERIOD  = 20;
    localparam int          JOB_TIMEOUT = 2000;
    localparam int          APB_TIMEOUT = 16;
    localparam int          VEC_LEN     = 16;
    localparam logic [31:0] SRC_A_BASE  = 32'h0000_1000;
    localparam logic [31:0] SRC_B_BASE  = 32'h0000_2000;
    localparam logic [31:0] SEED        = 32'h4e10_d113;

    logic                        clk;
    logic                        rst_n;
    apb_req_t                    apb_req;
    apb_rsp_t                    apb_rsp;
    tcdm_req_t                   port_req [2];
    tcdm_rsp_t                   port_rsp [2] = '{default: '0};
    logic                        evt;
    logic                        busy;
    logic [`HWPE_DATA_WIDTH-1:0] mem [2][VEC_LEN];
    logic                        granted [2] = '{default: 1'b0};
    logic [31:0]                 gnt_addr [2] = '{default: '0};
    int unsigned                 next_word [2] = '{default: 0};
    int unsigned                 gnt_pct = 100;
    int                          checks = 0;
    int                          errors = 0;
    int                          errors_at_start = 0;
    logic [31:0]                 rd;
    logic                        slverr;
    logic [31:0]                 expected;

    tb_clk_gen i_clk_gen (
        .clk_o ( clk )
    );

    fc_hwpe i_dut (
        .clk_i        ( clk         ),
        .rst_n_i      ( rst_n       ),
        .apb_req_i    ( apb_req     ),
        .apb_rsp_o    ( apb_rsp     ),
        .tcdm_a_req_o ( port_req[0] ),
        .tcdm_a_rsp_i ( port_rsp[0] ),
        .tcdm_b_req_o ( port_req[1] ),
        .tcdm_b_rsp_i ( port_rsp[1] ),
        .evt_o        ( evt         ),
        .busy_o       ( busy        )
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s got %08h expected %08h", name, got, exp);
            errors++;
        end
    endtask

    // each granted request must be a full-word read of the next word of its vector
    task automatic check_request(input int p);
        string       port_name;
        logic [31:0] exp_add;
        port_name = (p == 0) ? "tcdm_a_req_o" : "tcdm_b_req_o";
        exp_add   = ((p == 0) ? SRC_A_BASE : SRC_B_BASE) + 32'(4 * next_word[p]);
        check_value({port_name, ".add"}, port_req[p].add, exp_add);
        check_value({port_name, ".wen"}, 32'(port_req[p].wen), 32'h1);
        check_value({port_name, ".be"}, 32'(port_req[p].be), 32'hF);
        next_word[p]++;
    endtask

    // gnt is decided before the rising edge, the data follows one cycle later
    always @(negedge clk) begin
        for (int p = 0; p < 2; p++) begin
            port_rsp[p].r_valid = granted[p];
            port_rsp[p].r_rdata = granted[p] ? mem[p][gnt_addr[p][5:2]] : '0;
            port_rsp[p].gnt     = port_req[p].req && ($urandom_range(99) < gnt_pct);
            if (port_rsp[p].gnt) begin
                check_request(p);
            end
            granted[p]          = port_rsp[p].gnt;
            gnt_addr[p]         = port_req[p].add;
        end
    end

    task automatic end_test(input int num, input string what);
        $display("test %0d %s done, %0d errors", num, what, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic apb_access(input logic write, input logic [7:0] offset,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int n;
        n = 0;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = {24'h0, offset};
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        // the response is read a quarter period into the access phase
        #(CLK_PERIOD / 4);
        while (!apb_rsp.pready && n < APB_TIMEOUT) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            n++;
        end
        if (!apb_rsp.pready) begin
            $display("Timeout: pready stayed low for %0d cycles", APB_TIMEOUT);
            errors++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic write_reg(input logic [7:0] offset, input logic [31:0] wdata);
        logic [31:0] unused_rdata;
        logic        err;
        apb_access(1'b1, offset, wdata, unused_rdata, err);
        check_value("pslverr", 32'(err), 32'h0);
    endtask

    task automatic read_reg(input logic [7:0] offset, output logic [31:0] rdata);
        logic err;
        apb_access(1'b0, offset, 32'h0, rdata, err);
        check_value("pslverr", 32'(err), 32'h0);
    endtask

    // busy rises one cycle after the start pulse
    task automatic start_job();
        next_word[0] = 0;
        next_word[1] = 0;
        write_reg(REG_CTRL, 32'h1);
        @(negedge clk);
    endtask

    task automatic wait_job_end(input logic [31:0] exp_result);
        int          n;
        int          idle_cycles;
        int          extra_evt;
        logic [31:0] result;
        n           = 0;
        idle_cycles = 0;
        extra_evt   = 0;
        while (!evt && n < JOB_TIMEOUT) begin
            if (!busy) begin
                idle_cycles++;
            end
            @(negedge clk);
            n++;
        end
        if (!evt) begin
            $display("Timeout: evt_o did not rise within %0d cycles", JOB_TIMEOUT);
            errors++;
        end
        check_value("cycles with busy_o low before evt_o", 32'(idle_cycles), 32'h0);
        check_value("busy_o during evt_o", 32'(busy), 32'h0);
        repeat (4) begin
            @(negedge clk);
            if (evt) begin
                extra_evt++;
            end
        end
        check_value("extra evt_o pulses", 32'(extra_evt), 32'h0);
        read_reg(REG_RESULT, result);
        check_value("RESULT", result, exp_result);
    endtask

    // reference dot product, wrapping at 32 bits
    function automatic logic [31:0] dot_product(input int len);
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < len; i++) begin
            sum = sum + mem[0][i] * mem[1][i];
        end
        return sum;
    endfunction

    initial begin
        rst_n   = 1'b0;
        apb_req = '0;
        void'($urandom(SEED));
        for (int i = 0; i < VEC_LEN; i++) begin
            mem[0][i] = $urandom();
            mem[1][i] = $urandom();
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        check_value("busy_o", 32'(busy), 32'h0);
        check_value("evt_o", 32'(evt), 32'h0);
        read_reg(REG_STATUS, rd);
        check_value("STATUS", rd, 32'h0);
        write_reg(REG_SRC_A, SRC_A_BASE);
        write_reg(REG_SRC_B, SRC_B_BASE);
        write_reg(REG_LEN, 32'(VEC_LEN));
        read_reg(REG_SRC_A, rd);
        check_value("SRC_A", rd, SRC_A_BASE);
        read_reg(REG_SRC_B, rd);
        check_value("SRC_B", rd, SRC_B_BASE);
        read_reg(REG_LEN, rd);
        check_value("LEN", rd, 32'(VEC_LEN));
        end_test(1, "reset values and register readback");

        expected = dot_product(VEC_LEN);
        gnt_pct  = 100;
        start_job();
        wait_job_end(expected);
        end_test(2, "16 words with gnt always high");

        gnt_pct = 30;
        start_job();
        wait_job_end(expected);
        end_test(3, "16 words with random 30% gnt");

        write_reg(REG_LEN, 32'h0);
        start_job();
        wait_job_end(32'h0);
        end_test(4, "empty job");

        apb_access(1'b0, 8'h20, 32'h0, rd, slverr);
        check_value("pslverr on unmapped offset", 32'(slverr), 32'h1);
        write_reg(REG_LEN, 32'(VEC_LEN));
        start_job();
        repeat (5) @(negedge clk);
        read_reg(REG_STATUS, rd);
        check_value("STATUS", rd, 32'h1);
        apb_access(1'b1, REG_CTRL, 32'h1, rd, slverr);
        check_value("pslverr on CTRL write while busy", 32'(slverr), 32'h1);
        wait_job_end(expected);
        end_test(5, "slave errors");

        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, i_dut.i_sva.fail_count);
        if (errors == 0 && i_dut.i_sva.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
hwpe_pkg.sv
hwpe_cfg_regs.sv
hwpe_stream_loader.sv
hwpe_mac_engine.sv
fc_hwpe.sv
tb_clk_gen.sv
tb_fc_hwpe_sva.sv
tb_fc_hwpe.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fc_hwpe -f tb.f || exit 1
./obj_dir/Vtb_fc_hwpe > sim.log 2>&1
cat sim.log
grep -qx "All checks passed" sim.log && exit 0 || exit 1
